//--- adder_tree.sv
`default_nettype none

module adder_tree (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    advance_i,
    input  logic                    valid_i,
    input  conv1_arith_pkg::terms_t terms_i,
    output conv1_arith_pkg::wgt_t   sum_o,
    output logic                    valid_o
);

    // partial sums per level: 26 -> 13 -> 7 -> 4 -> 2 -> 1
    conv1_arith_pkg::wgt_t             l1_q [13];
    conv1_arith_pkg::wgt_t             l2_q [7];
    conv1_arith_pkg::wgt_t             l3_q [4];
    conv1_arith_pkg::wgt_t             l4_q [2];
    logic [conv1_arith_pkg::TREE_LEVELS-1:0] vld_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (advance_i) begin
            vld_q <= {vld_q[conv1_arith_pkg::TREE_LEVELS-2:0], valid_i};
        end
    end

    assign valid_o = vld_q[conv1_arith_pkg::TREE_LEVELS-1];

    // sums truncate to 16 bits, so overflow wraps
    always_ff @(posedge clk) begin
        if (advance_i) begin
            for (int i = 0; i < 13; i++) begin
                l1_q[i] <= terms_i[2*i] + terms_i[2*i+1];
            end

            for (int i = 0; i < 6; i++) begin
                l2_q[i] <= l1_q[2*i] + l1_q[2*i+1];
            end
            // odd one out passes through
            l2_q[6] <= l1_q[12];

            for (int i = 0; i < 3; i++) begin
                l3_q[i] <= l2_q[2*i] + l2_q[2*i+1];
            end
            l3_q[3] <= l2_q[6];

            l4_q[0] <= l3_q[0] + l3_q[1];
            l4_q[1] <= l3_q[2] + l3_q[3];

            sum_o <= l4_q[0] + l4_q[1];
        end
    end

endmodule

`default_nettype wire

//--- conv1_arith_pkg.sv
`default_nettype none

package conv1_arith_pkg;

    localparam int N_CH        = 6;
    localparam int WGT_W       = 16;
    // 25 masked taps plus the bias
    localparam int N_TERMS     = conv1_geom_pkg::KER_TAPS + 1;
    localparam int TREE_LEVELS = 5;

    // weights, biases and sums share one width and wrap on overflow
    typedef logic signed [WGT_W-1:0] wgt_t;

    // taps of one channel, same index order as window_t
    typedef wgt_t [conv1_geom_pkg::KER_TAPS-1:0] kernel_t;

    // term N_TERMS-1 carries the bias
    typedef wgt_t [N_TERMS-1:0] terms_t;

    // one output vector, channel 0 in the low word
    typedef wgt_t [N_CH-1:0] feature_t;

    // weight port beat
    // tap 0..24 hits a weight, tap 25 the bias of the channel
    typedef struct packed {
        logic [2:0] ch;
        logic [4:0] tap;
        wgt_t       value;
    } wgt_wr_t;

endpackage

`default_nettype wire

//--- conv1_geom_pkg.sv
`default_nettype none

package conv1_geom_pkg;

    // square binary image, one bit per pixel
    localparam int IMG_W    = 28;
    localparam int KER_W    = 5;
    localparam int KER_TAPS = KER_W * KER_W;
    localparam int POS_W    = 5;

    // x or y position inside the image
    typedef logic [POS_W-1:0] pos_t;

    // tap = row * KER_W + col
    // row 0 is the oldest row, col 0 the oldest pixel
    typedef logic [KER_TAPS-1:0] window_t;

    typedef struct packed {
        logic    valid;
        window_t win;
    } window_beat_t;

    typedef enum logic {
        FRAME_IDLE = 1'b0,
        FRAME_RUN  = 1'b1
    } frame_state_e;

endpackage

`default_nettype wire

//--- conv1_tb.sv
`default_nettype none

module conv1_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int OUT_W      = conv1_geom_pkg::IMG_W - conv1_geom_pkg::KER_W + 1;
    localparam int N_OUT      = OUT_W * OUT_W;
    localparam int N_PIX      = conv1_geom_pkg::IMG_W * conv1_geom_pkg::IMG_W;
    localparam int N_FRAMES   = 4;
    localparam int MAX_CYCLES = N_FRAMES * N_PIX * 4 + 1000;
    localparam int W_RANDOM   = 0;
    localparam int W_NEGATIVE = 1;
    localparam int W_ZERO     = 2;

    logic                      clk;
    logic                      rst_n;
    logic                      pix_valid_i;
    logic                      pix_i;
    logic                      pix_ready_o;
    logic                      wr_valid_i;
    conv1_arith_pkg::wgt_wr_t  wr_i;
    logic                      wr_ready_o;
    logic                      out_valid_o;
    conv1_arith_pkg::feature_t out_o;
    logic                      out_ready_i;

    integer                    seed;
    integer                    ready_seed = 7;
    logic                      img [conv1_geom_pkg::IMG_W][conv1_geom_pkg::IMG_W];
    conv1_arith_pkg::wgt_t     wgt_tb [conv1_arith_pkg::N_CH][conv1_geom_pkg::KER_TAPS];
    conv1_arith_pkg::wgt_t     bias_tb [conv1_arith_pkg::N_CH];
    conv1_arith_pkg::feature_t expect_q [$];
    conv1_arith_pkg::feature_t held_value;
    logic                      held;
    logic                      stall_mode;
    int                        n_results;
    int                        n_stalls;
    int                        n_zero;
    int                        cycle_count;

    conv1_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pix_valid_i (pix_valid_i),
        .pix_i       (pix_i),
        .pix_ready_o (pix_ready_o),
        .wr_valid_i  (wr_valid_i),
        .wr_i        (wr_i),
        .wr_ready_o  (wr_ready_o),
        .out_valid_o (out_valid_o),
        .out_o       (out_o),
        .out_ready_i (out_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_feature(input string name, input conv1_arith_pkg::feature_t got,
                                 input conv1_arith_pkg::feature_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // idx runs over the 24x24 outputs in raster order
    function automatic conv1_arith_pkg::feature_t expected_feature(
        input logic                  image [conv1_geom_pkg::IMG_W][conv1_geom_pkg::IMG_W],
        input conv1_arith_pkg::wgt_t wgt [conv1_arith_pkg::N_CH][conv1_geom_pkg::KER_TAPS],
        input conv1_arith_pkg::wgt_t bias [conv1_arith_pkg::N_CH],
        input int                    idx
    );
        conv1_arith_pkg::feature_t res;
        conv1_arith_pkg::wgt_t     acc;
        int                        ox;
        int                        oy;
        ox = idx % OUT_W;
        oy = idx / OUT_W;
        for (int ch = 0; ch < conv1_arith_pkg::N_CH; ch++) begin
            acc = bias[ch];
            for (int r = 0; r < conv1_geom_pkg::KER_W; r++) begin
                for (int c = 0; c < conv1_geom_pkg::KER_W; c++) begin
                    // only set pixels contribute, sum wraps at 16 bits
                    if (image[oy+r][ox+c]) begin
                        acc = acc + wgt[ch][r*conv1_geom_pkg::KER_W+c];
                    end
                end
            end
            res[ch] = acc[conv1_arith_pkg::WGT_W-1] ? '0 : acc;
        end
        return res;
    endfunction

    task automatic queue_frame_results(output int zeros);
        conv1_arith_pkg::feature_t f;
        zeros = 0;
        for (int i = 0; i < N_OUT; i++) begin
            f = expected_feature(img, wgt_tb, bias_tb, i);
            expect_q.push_back(f);
            for (int ch = 0; ch < conv1_arith_pkg::N_CH; ch++) begin
                if (f[ch] == '0) zeros++;
            end
        end
    endtask

    task automatic make_image(input bit blank);
        logic [31:0] raw;
        for (int y = 0; y < conv1_geom_pkg::IMG_W; y++) begin
            for (int x = 0; x < conv1_geom_pkg::IMG_W; x++) begin
                raw = $random(seed);
                img[y][x] = blank ? 1'b0 : raw[0];
            end
        end
    endtask

    task automatic make_weights(input int mode);
        logic [31:0] raw;
        for (int ch = 0; ch < conv1_arith_pkg::N_CH; ch++) begin
            for (int t = 0; t < conv1_geom_pkg::KER_TAPS; t++) begin
                raw = $random(seed);
                case (mode)
                    W_RANDOM:   wgt_tb[ch][t] = raw[15:0];
                    // one in eight small positive, the rest -1 down to -1024
                    W_NEGATIVE: wgt_tb[ch][t] = (raw[31:29] == 3'd0) ? {8'd0, raw[7:0]}
                                                                    : 16'hffff - {6'd0, raw[9:0]};
                    default:    wgt_tb[ch][t] = '0;
                endcase
            end
            raw = $random(seed);
            bias_tb[ch] = (mode == W_NEGATIVE) ? {{10{raw[5]}}, raw[5:0]} : raw[15:0];
        end
    endtask

    // leaves wr_valid_i high at the falling edge after the handshake
    task automatic write_weight(input int ch, input int tap, input conv1_arith_pkg::wgt_t value);
        wr_valid_i = 1'b1;
        wr_i.ch    = ch[2:0];
        wr_i.tap   = tap[4:0];
        wr_i.value = value;
        @(posedge clk);
        while (!wr_ready_o) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic load_kernels();
        for (int ch = 0; ch < conv1_arith_pkg::N_CH; ch++) begin
            for (int t = 0; t < conv1_geom_pkg::KER_TAPS; t++) begin
                write_weight(ch, t, wgt_tb[ch][t]);
            end
            write_weight(ch, conv1_geom_pkg::KER_TAPS, bias_tb[ch]);
        end
        // out of range channel and tap, both dropped
        write_weight(conv1_arith_pkg::N_CH, 0, 16'h1234);
        write_weight(0, conv1_geom_pkg::KER_TAPS + 1, 16'h1234);
        wr_valid_i = 1'b0;
    endtask

    task automatic send_pixel(input logic value, input bit gaps);
        logic [31:0] raw;
        raw = $random(seed);
        while (gaps && raw[1:0] == 2'b00) begin
            pix_valid_i = 1'b0;
            pix_i       = raw[2];
            @(negedge clk);
            raw = $random(seed);
        end
        pix_valid_i = 1'b1;
        pix_i       = value;
        @(posedge clk);
        while (!pix_ready_o) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic send_frame(input bit gaps, input bit probe_write);
        for (int y = 0; y < conv1_geom_pkg::IMG_W; y++) begin
            for (int x = 0; x < conv1_geom_pkg::IMG_W; x++) begin
                if (probe_write && y == 12 && x == 0) begin
                    // would change channel 0 tap 0 if it landed
                    wr_valid_i = 1'b1;
                    wr_i.ch    = 3'd0;
                    wr_i.tap   = 5'd0;
                    wr_i.value = ~wgt_tb[0][0];
                end
                if (probe_write && y == 12 && x == 10) begin
                    wr_valid_i = 1'b0;
                end
                if (wr_valid_i) begin
                    check_bit("wr_ready_o", wr_ready_o, 1'b0);
                end
                send_pixel(img[y][x], gaps);
            end
        end
        pix_valid_i = 1'b0;
    endtask

    initial begin
        logic [31:0] raw;
        out_ready_i = 1'b1;
        forever begin
            @(negedge clk);
            raw = $random(ready_seed);
            out_ready_i = stall_mode ? raw[0] : 1'b1;
        end
    end

    // output handshake, stall hold and ready rule
    always @(posedge clk) begin
        if (rst_n) begin
            check_bit("pix_ready_o", pix_ready_o, !out_valid_o || out_ready_i);
            if (held) begin
                check_bit("out_valid_o", out_valid_o, 1'b1);
                check_feature("out_o", out_o, held_value);
            end
            if (out_valid_o && out_ready_i) begin
                if (expect_q.size() == 0) begin
                    $display("extra output beat at %0d ns with no result left to expect", $time);
                    stop_with_failure();
                end else begin
                    check_feature("out_o", out_o, expect_q.pop_front());
                    n_results++;
                end
            end
            if (out_valid_o && !out_ready_i) n_stalls++;
            held       = out_valid_o && !out_ready_i;
            held_value = out_o;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not finish", MAX_CYCLES);
        stop_with_failure();
    end

    initial begin
        seed        = 7;
        rst_n       = 1'b0;
        pix_valid_i = 1'b0;
        pix_i       = 1'b0;
        wr_valid_i  = 1'b0;
        wr_i        = '0;
        stall_mode  = 1'b0;
        held        = 1'b0;
        n_results   = 0;
        n_stalls    = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("out_valid_o", out_valid_o, 1'b0);
        check_bit("wr_ready_o", wr_ready_o, 1'b1);
        check_bit("pix_ready_o", pix_ready_o, 1'b1);

        // random kernels, output always ready
        make_weights(W_RANDOM);
        load_kernels();
        make_image(1'b0);
        queue_frame_results(n_zero);
        send_frame(1'b0, 1'b0);

        // same kernels with input gaps, output stalls and a locked weight port
        make_image(1'b0);
        queue_frame_results(n_zero);
        @(posedge clk);
        stall_mode = 1'b1;
        @(negedge clk);
        send_frame(1'b1, 1'b1);
        while (expect_q.size() != 0) @(posedge clk);
        stall_mode = 1'b0;
        @(negedge clk);

        // mostly negative kernels
        make_weights(W_NEGATIVE);
        load_kernels();
        make_image(1'b0);
        queue_frame_results(n_zero);
        if (n_zero == 0) begin
            $display("negative kernel frame never reaches the relu clamp");
            stop_with_failure();
        end
        send_frame(1'b0, 1'b0);

        // blank image and zero kernels, bias only
        make_weights(W_ZERO);
        bias_tb[0] = 16'h0064;
        bias_tb[1] = 16'hfffb;
        bias_tb[2] = 16'h0000;
        bias_tb[3] = 16'h7fff;
        bias_tb[4] = 16'h8000;
        bias_tb[5] = 16'h0001;
        load_kernels();
        make_image(1'b1);
        queue_frame_results(n_zero);
        send_frame(1'b0, 1'b0);

        while (expect_q.size() != 0) @(posedge clk);
        // room for a stray beat to show up
        repeat (20) @(posedge clk);
        if (n_results == N_FRAMES * N_OUT && n_stalls > 0 && !out_valid_o) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("expected %0d results and saw %0d, with %0d stalled cycles",
                     N_FRAMES * N_OUT, n_results, n_stalls);
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- conv1_top.sv
`default_nettype none

module conv1_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pix_valid_i,
    input  logic                      pix_i,
    output logic                      pix_ready_o,
    input  logic                      wr_valid_i,
    input  conv1_arith_pkg::wgt_wr_t  wr_i,
    output logic                      wr_ready_o,
    output logic                      out_valid_o,
    output conv1_arith_pkg::feature_t out_o,
    input  logic                      out_ready_i
);

    logic                             advance;
    logic                             frame_idle;
    conv1_geom_pkg::window_beat_t     win;
    conv1_arith_pkg::kernel_t         kernels [conv1_arith_pkg::N_CH];
    conv1_arith_pkg::wgt_t            biases [conv1_arith_pkg::N_CH];
    conv1_arith_pkg::terms_t          terms [conv1_arith_pkg::N_CH];
    logic                             prod_valid;
    conv1_arith_pkg::wgt_t            sums [conv1_arith_pkg::N_CH];
    logic [conv1_arith_pkg::N_CH-1:0] sum_valid;

    // a pixel enters only when the pipeline moves
    assign pix_ready_o = advance;

    pixel_intake u_intake (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid_i  (pix_valid_i),
        .pix_i        (pix_i),
        .advance_i    (advance),
        .win_o        (win),
        .frame_idle_o (frame_idle)
    );

    kernel_store u_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_valid_i   (wr_valid_i),
        .wr_i         (wr_i),
        .frame_idle_i (frame_idle),
        .wr_ready_o   (wr_ready_o),
        .kernels_o    (kernels),
        .biases_o     (biases)
    );

    masked_product u_product (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance_i (advance),
        .win_i     (win),
        .kernels_i (kernels),
        .biases_i  (biases),
        .terms_o   (terms),
        .valid_o   (prod_valid)
    );

    // one tree per output channel
    for (genvar ch = 0; ch < conv1_arith_pkg::N_CH; ch++) begin : g_tree
        adder_tree u_tree (
            .clk       (clk),
            .rst_n     (rst_n),
            .advance_i (advance),
            .valid_i   (prod_valid),
            .terms_i   (terms[ch]),
            .sum_o     (sums[ch]),
            .valid_o   (sum_valid[ch])
        );
    end

    relu_output u_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .sums_i      (sums),
        .valid_i     (sum_valid),
        .out_ready_i (out_ready_i),
        .advance_o   (advance),
        .out_valid_o (out_valid_o),
        .out_o       (out_o)
    );

endmodule

`default_nettype wire

//--- kernel_store.sv
`default_nettype none

module kernel_store (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_valid_i,
    input  conv1_arith_pkg::wgt_wr_t wr_i,
    input  logic                     frame_idle_i,
    output logic                     wr_ready_o,
    output conv1_arith_pkg::kernel_t kernels_o [conv1_arith_pkg::N_CH],
    output conv1_arith_pkg::wgt_t    biases_o [conv1_arith_pkg::N_CH]
);

    logic wr_fire;
    logic ch_ok;
    logic is_weight;
    logic is_bias;

    // weights only change between frames
    assign wr_ready_o = frame_idle_i;
    assign wr_fire    = wr_valid_i && frame_idle_i;

    // out of range beats are taken and dropped
    assign ch_ok     = (wr_i.ch < conv1_arith_pkg::N_CH);
    assign is_weight = (wr_i.tap < conv1_geom_pkg::KER_TAPS);
    assign is_bias   = (wr_i.tap == conv1_geom_pkg::KER_TAPS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kernels_o <= '{default: '0};
        end else if (wr_fire && ch_ok && is_weight) begin
            kernels_o[wr_i.ch][wr_i.tap] <= wr_i.value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            biases_o <= '{default: '0};
        end else if (wr_fire && ch_ok && is_bias) begin
            biases_o[wr_i.ch] <= wr_i.value;
        end
    end

endmodule

`default_nettype wire

//--- masked_product.sv
`default_nettype none

module masked_product (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         advance_i,
    input  conv1_geom_pkg::window_beat_t win_i,
    input  conv1_arith_pkg::kernel_t     kernels_i [conv1_arith_pkg::N_CH],
    input  conv1_arith_pkg::wgt_t        biases_i [conv1_arith_pkg::N_CH],
    output conv1_arith_pkg::terms_t      terms_o [conv1_arith_pkg::N_CH],
    output logic                         valid_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= win_i.valid;
        end
    end

    // binary pixels, so the multiply is a select
    always_ff @(posedge clk) begin
        if (advance_i) begin
            for (int ch = 0; ch < conv1_arith_pkg::N_CH; ch++) begin
                for (int t = 0; t < conv1_geom_pkg::KER_TAPS; t++) begin
                    terms_o[ch][t] <= win_i.win[t] ? kernels_i[ch][t] : '0;
                end
                // bias always counts
                terms_o[ch][conv1_arith_pkg::N_TERMS-1] <= biases_i[ch];
            end
        end
    end

endmodule

`default_nettype wire

//--- pixel_intake.sv
`default_nettype none

module pixel_intake (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pix_valid_i,
    input  logic                         pix_i,
    input  logic                         advance_i,
    output conv1_geom_pkg::window_beat_t win_o,
    output logic                         frame_idle_o
);

    conv1_geom_pkg::frame_state_e     state_q;
    conv1_geom_pkg::pos_t             x_q;
    conv1_geom_pkg::pos_t             y_q;
    logic                             accept;
    logic                             x_last;
    logic                             y_last;
    logic                             acc_q;
    logic                             in_win_q;
    logic                             pix_q;
    logic                             win_vld_q;
    conv1_geom_pkg::window_t          win_q;
    wire  [conv1_geom_pkg::KER_W-1:0] col;

    assign accept = pix_valid_i && advance_i;
    assign x_last = (x_q == conv1_geom_pkg::pos_t'(conv1_geom_pkg::IMG_W - 1));
    assign y_last = (y_q == conv1_geom_pkg::pos_t'(conv1_geom_pkg::IMG_W - 1));

    // raster position of the next pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_q <= '0;
            y_q <= '0;
        end else if (accept) begin
            if (x_last) begin
                x_q <= '0;
                y_q <= y_last ? '0 : y_q + 1'b1;
            end else begin
                x_q <= x_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= conv1_geom_pkg::FRAME_IDLE;
        end else begin
            case (state_q)
                conv1_geom_pkg::FRAME_IDLE: begin
                    if (accept) state_q <= conv1_geom_pkg::FRAME_RUN;
                end
                conv1_geom_pkg::FRAME_RUN: begin
                    // last pixel of the frame closes it
                    if (accept && x_last && y_last) state_q <= conv1_geom_pkg::FRAME_IDLE;
                end
                default: state_q <= conv1_geom_pkg::FRAME_IDLE;
            endcase
        end
    end

    // accepted pixel waits here one advancing cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q    <= 1'b0;
            in_win_q <= 1'b0;
        end else if (advance_i) begin
            acc_q    <= pix_valid_i;
            in_win_q <= (x_q >= conv1_geom_pkg::KER_W - 1) && (y_q >= conv1_geom_pkg::KER_W - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) pix_q <= pix_i;
    end

    // newest row straight from the staged pixel, older rows from the line buffers
    assign col[conv1_geom_pkg::KER_W-1] = pix_q;

    for (genvar r = 0; r < conv1_geom_pkg::KER_W - 1; r++) begin : g_row
        row_delay_line #(
            .DEPTH (conv1_geom_pkg::IMG_W)
        ) u_row (
            .clk     (clk),
            .rst_n   (rst_n),
            .shift_i (advance_i && acc_q),
            .bit_i   (col[r+1]),
            .bit_o   (col[r])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_vld_q <= 1'b0;
        end else if (advance_i) begin
            win_vld_q <= acc_q && in_win_q;
        end
    end

    // shift every window row left, new column enters at col 4
    always_ff @(posedge clk) begin
        if (advance_i && acc_q) begin
            for (int r = 0; r < conv1_geom_pkg::KER_W; r++) begin
                for (int c = 0; c < conv1_geom_pkg::KER_W - 1; c++) begin
                    win_q[r*conv1_geom_pkg::KER_W+c] <= win_q[r*conv1_geom_pkg::KER_W+c+1];
                end
                win_q[r*conv1_geom_pkg::KER_W+conv1_geom_pkg::KER_W-1] <= col[r];
            end
        end
    end

    assign win_o.valid = win_vld_q;
    assign win_o.win   = win_q;

    // idle only once the last window has left for the products
    assign frame_idle_o = (state_q == conv1_geom_pkg::FRAME_IDLE) && !acc_q && !win_vld_q;

endmodule

`default_nettype wire

//--- relu_output.sv
`default_nettype none

module relu_output (
    input  logic                              clk,
    input  logic                              rst_n,
    input  conv1_arith_pkg::wgt_t             sums_i [conv1_arith_pkg::N_CH],
    input  logic [conv1_arith_pkg::N_CH-1:0]  valid_i,
    input  logic                              out_ready_i,
    output logic                              advance_o,
    output logic                              out_valid_o,
    output conv1_arith_pkg::feature_t         out_o
);

    conv1_arith_pkg::feature_t relu;

    // negative sums clamp to zero
    always_comb begin
        for (int ch = 0; ch < conv1_arith_pkg::N_CH; ch++) begin
            relu[ch] = sums_i[ch][conv1_arith_pkg::WGT_W-1] ? '0 : sums_i[ch];
        end
    end

    // whole pipeline moves only when this register can take a beat
    assign advance_o = !out_valid_o || out_ready_i;

    // all channel trees run in lockstep
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_o <= 1'b0;
        end else if (advance_o) begin
            out_valid_o <= &valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) out_o <= relu;
    end

endmodule

`default_nettype wire

//--- row_delay_line.sv
`default_nettype none

module row_delay_line #(
    parameter int DEPTH = 28
) (
    input  logic clk,
    input  logic rst_n,
    input  logic shift_i,
    input  logic bit_i,
    output logic bit_o
);

    logic [DEPTH-1:0] sr_q;

    // one stage per pixel of a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sr_q <= '0;
        end else if (shift_i) begin
            sr_q <= {sr_q[DEPTH-2:0], bit_i};
        end
    end

    // same column, one row up
    assign bit_o = sr_q[DEPTH-1];

endmodule

`default_nettype wire

//--- sources.f
conv1_geom_pkg.sv
conv1_arith_pkg.sv
row_delay_line.sv
pixel_intake.sv
kernel_store.sv
masked_product.sv
adder_tree.sv
relu_output.sv
conv1_top.sv
conv1_tb.sv
